// File: tb.f
+incdir+source
+incdir+verification
source/cpu_pkg.sv
source/decoded_if.sv
source/cpu_decode.sv
source/cpu_execute.sv
source/cpu_result.sv
source/cpu_top.sv
verification/tb_cpu.sv

// File: run.sh
#!/bin/sh
verilator --binary --top-module tb_cpu -f tb.f \
	&& ./obj_dir/Vtb_cpu | tee /dev/stderr | grep -q "Simulation completed successfully" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

// File: verification/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// Rows by operand form in src_t order, columns by ALU operation
opcode_t alu_opcodes [6][7] = '{
	'{OP_ADD_IMM, OP_ADC_IMM, OP_SUB_IMM, OP_SBC_IMM, OP_AND_IMM, OP_OR_IMM, OP_XOR_IMM},
	'{OP_ADD_XH, OP_ADC_XH, OP_SUB_XH, OP_SBC_XH, OP_AND_XH, OP_OR_XH, OP_XOR_XH},
	'{OP_ADD_YL, OP_ADC_YL, OP_SUB_YL, OP_SBC_YL, OP_AND_YL, OP_OR_YL, OP_XOR_YL},
	'{OP_ADD_YH, OP_ADC_YH, OP_SUB_YH, OP_SBC_YH, OP_AND_YH, OP_OR_YH, OP_XOR_YH},
	'{OP_ADD_ZL, OP_ADC_ZL, OP_SUB_ZL, OP_SBC_ZL, OP_AND_ZL, OP_OR_ZL, OP_XOR_ZL},
	'{OP_ADD_DIR, OP_ADC_DIR, OP_SUB_DIR, OP_SBC_DIR, OP_AND_DIR, OP_OR_DIR, OP_XOR_DIR}
};
opcode_t jr_opcodes [7] = '{OP_JR, OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC, OP_JRN, OP_JRNN};
opcode_t ldw_opcodes [3] = '{OP_LDW_X_IMM, OP_LDW_Y_IMM, OP_LDW_Z_IMM};

// Returns flags in bits 12:8 and the xl result in bits 7:0
function automatic logic [12:0] alu_ref(alu_op_t op, logic [7:0] a, logic [7:0] b,
	logic [4:0] flags_in);
	logic [4:0] f;
	logic [7:0] r;
	logic [7:0] addend;
	int carry;
	int sum;
	int signed_sum;
	f = flags_in;
	case (op)
		ALU_AND: r = a & b;
		ALU_OR: r = a | b;
		ALU_XOR: r = a ^ b;
		default:
		begin
			addend = (op == ALU_SUB || op == ALU_SBC) ? ~b : b;
			if (op == ALU_ADD)
				carry = 0;
			else if (op == ALU_SUB)
				carry = 1;
			else
				carry = int'(flags_in[FLAG_C]); // adc and sbc
			sum = int'(a) + int'(addend) + carry;
			signed_sum = int'($signed(a)) + int'($signed(addend)) + carry;
			r = sum[7:0];
			f[FLAG_C] = sum > 255;
			f[FLAG_H] = int'(a[3:0]) + int'(addend[3:0]) + carry > 15;
			f[FLAG_O] = signed_sum > 127 || signed_sum < -128;
		end
	endcase
	f[FLAG_N] = r[7];
	f[FLAG_Z] = r == 8'h00;
	return {f, r};
endfunction

function automatic logic cond_holds(cond_t c, logic [4:0] f);
	case (c)
		COND_Z: return f[FLAG_Z];
		COND_NZ: return !f[FLAG_Z];
		COND_C: return f[FLAG_C];
		COND_NC: return !f[FLAG_C];
		COND_N: return f[FLAG_N];
		COND_NN: return !f[FLAG_N];
		default: return 1'b1;
	endcase
endfunction

function automatic void byte_out(logic [7:0] b);
	image.push_back({loc, b});
	loc = loc + 16'd1;
endfunction

// Little endian operand words
function automatic void word_out(logic [15:0] w);
	byte_out(w[7:0]);
	byte_out(w[15:8]);
endfunction

function automatic void alu_instr(alu_op_t op, src_t form, logic [15:0] arg);
	byte_out(alu_opcodes[form][op]);
	if (form == SRC_IMM)
		byte_out(arg[7:0]);
	else if (form == SRC_MEM)
		word_out(arg);
endfunction

function automatic void ld_xl_imm(logic [7:0] v);
	byte_out(OP_LD_XL_IMM);
	byte_out(v);
endfunction

function automatic void ld_xl_dir(logic [15:0] addr);
	byte_out(OP_LD_XL_DIR);
	word_out(addr);
endfunction

function automatic void st_xl(logic [15:0] addr);
	byte_out(OP_LD_DIR_XL);
	word_out(addr);
endfunction

function automatic void ldw_imm(int r, logic [15:0] w);
	byte_out(ldw_opcodes[r]); // 0 x, 1 y, 2 z
	word_out(w);
endfunction

function automatic void jp_abs(logic [15:0] target);
	byte_out(OP_JP_IMM);
	word_out(target);
endfunction

// Displacement counts from the jr opcode itself
function automatic void jr_rel(cond_t c, logic [7:0] disp);
	byte_out(jr_opcodes[c]);
	byte_out(disp);
endfunction

function automatic void pad_nop();
	byte_out(OP_NOP);
endfunction

function automatic void halt();
	byte_out(OP_TRAP);
endfunction

function automatic void data_byte(logic [15:0] addr, logic [7:0] v);
	image.push_back({addr, v});
endfunction

`endif

// File: verification/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module tb_cpu;
	import cpu_pkg::*;

	logic clk;
	logic reset;
	logic [`CPU_BANK_ADDR_W-1:0] rd_addr_even;
	logic [`CPU_BANK_ADDR_W-1:0] rd_addr_odd;
	logic [`CPU_DATA_W-1:0] rd_data_even = '0;
	logic [`CPU_DATA_W-1:0] rd_data_odd = '0;
	logic [`CPU_BANK_ADDR_W-1:0] wr_addr_even;
	logic [`CPU_BANK_ADDR_W-1:0] wr_addr_odd;
	logic [`CPU_DATA_W-1:0] wr_data_even;
	logic [`CPU_DATA_W-1:0] wr_data_odd;
	logic wr_en_even;
	logic wr_en_odd;
	logic trap;
	logic load_en;
	logic [`CPU_ADDR_W-1:0] load_addr;
	logic [`CPU_DATA_W-1:0] load_data;
	logic [`CPU_DATA_W-1:0] bank_even [`CPU_BANK_DEPTH];
	logic [`CPU_DATA_W-1:0] bank_odd [`CPU_BANK_DEPTH];
	logic [23:0] image [$]; // Byte address and byte
	logic [23:0] expected_writes [$];
	logic [`CPU_ADDR_W-1:0] loc;
	logic [31:0] lfsr = 32'h39f43394;
	string test_name;
	int checks = 0;
	int write_errors = 0;
	int run_errors = 0;

	`include "cpu_model.svh"

	cpu_top uut (.clk, .reset, .rd_addr_even, .rd_data_even, .wr_addr_even, .wr_data_even,
		.wr_en_even, .rd_addr_odd, .rd_data_odd, .wr_addr_odd, .wr_data_odd, .wr_en_odd,
		.trap);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Banks with registered reads and loader priority over the DUT
	always @(posedge clk)
	begin
		rd_data_even <= bank_even[rd_addr_even];
		rd_data_odd <= bank_odd[rd_addr_odd];
		if (load_en)
		begin
			if (load_addr[0])
				bank_odd[load_addr[15:1]] <= load_data;
			else
				bank_even[load_addr[15:1]] <= load_data;
		end
		else
		begin
			if (wr_en_even)
				bank_even[wr_addr_even] <= wr_data_even;
			if (wr_en_odd)
				bank_odd[wr_addr_odd] <= wr_data_odd;
		end
	end

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
		end
		return v;
	endfunction

	function automatic logic [7:0] rand_byte();
		return 8'(rand_bits(8));
	endfunction

	function automatic alu_op_t random_op();
		return alu_op_t'(3'(rand_bits(3) % 7)); // add through xor
	endfunction

	function automatic void start_program(string name, int nops);
		int i;
		image.delete();
		loc = `CPU_RESET_PC;
		test_name = name;
		for (i = 0; i < nops; i++)
			pad_nop();
	endfunction

	function automatic void expect_write(logic [15:0] addr, logic [7:0] data);
		expected_writes.push_back({addr, data});
	endfunction

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		checks++;
		if (expected !== actual)
		begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			write_errors++;
		end
	endtask

	task automatic take_write(logic [15:0] addr, logic [7:0] data);
		if (expected_writes.size() == 0)
		begin
			$display("Unexpected write of %h to address %h in test %s", data, addr, test_name);
			write_errors++;
		end
		else
			check_value(test_name, 32'(expected_writes.pop_front()), 32'({addr, data}));
	endtask

	// Bank address back to a byte address so that a write in the wrong bank shows up
	always @(negedge clk)
	begin
		if (wr_en_even)
			take_write({wr_addr_even, 1'b0}, wr_data_even);
		if (wr_en_odd)
			take_write({wr_addr_odd, 1'b1}, wr_data_odd);
	end

	// Loads under reset, releases it and runs until trap
	task automatic run_program();
		int i;
		int waited;
		@(posedge clk);
		reset <= 1'b1;
		for (i = 0; i < image.size(); i++)
		begin
			@(posedge clk);
			load_en <= 1'b1;
			load_addr <= image[i][23:8];
			load_data <= image[i][7:0];
		end
		@(posedge clk);
		load_en <= 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		waited = 0;
		while (trap !== 1'b1 && waited < 100)
		begin
			@(negedge clk);
			waited++;
		end
		if (trap !== 1'b1)
		begin
			$display("Timeout: trap never rose in test %s", test_name);
			run_errors++;
		end
		else
		begin
			repeat (20) @(negedge clk); // Any write here is caught as unexpected
			if (trap !== 1'b1)
			begin
				$display("Trap did not stay high in test %s", test_name);
				run_errors++;
			end
		end
		if (expected_writes.size() != 0)
		begin
			$display("Test %s ended with %0d writes missing", test_name, expected_writes.size());
			run_errors++;
			expected_writes.delete();
		end
	endtask

	initial
	begin
		int n;
		int k;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] xl;
		logic [4:0] f;
		logic [12:0] res;
		logic [15:0] wx;
		logic [15:0] wy;
		logic [15:0] wz;
		logic [15:0] addr_even;
		logic [15:0] addr_odd;
		logic [15:0] dst;
		alu_op_t op;
		src_t reg_forms [4];
		reg_forms = '{SRC_YL, SRC_YH, SRC_ZL, SRC_XH};
		reset = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;

		for (n = 0; n < 40; n++)
		begin
			a = rand_byte();
			b = rand_byte();
			op = random_op();
			dst = 16'h6000 + 16'(rand_bits(4));
			start_program("alu_imm", int'(rand_bits(1)));
			ld_xl_imm(a);
			alu_instr(op, SRC_IMM, {8'h00, b});
			st_xl(dst);
			halt();
			res = alu_ref(op, a, b, 5'b0);
			expect_write(dst, res[7:0]);
			run_program();
		end

		for (n = 0; n < 10; n++)
		begin
			wx = 16'(rand_bits(16));
			wy = 16'(rand_bits(16));
			wz = 16'(rand_bits(16));
			start_program("reg_operands", int'(rand_bits(1)));
			ldw_imm(0, wx);
			ldw_imm(1, wy);
			ldw_imm(2, wz);
			xl = wx[7:0];
			f = 5'b0;
			for (k = 0; k < 4; k++)
			begin
				op = random_op();
				case (reg_forms[k])
					SRC_XH: b = wx[15:8]; // Must survive the xl writes
					SRC_YL: b = wy[7:0];
					SRC_YH: b = wy[15:8];
					default: b = wz[7:0];
				endcase
				alu_instr(op, reg_forms[k], 16'h0000);
				res = alu_ref(op, xl, b, f);
				xl = res[7:0];
				f = res[12:8];
				st_xl(16'h6010 + 16'(k));
				expect_write(16'h6010 + 16'(k), xl);
			end
			halt();
			run_program();
		end

		for (n = 0; n < 10; n++)
		begin
			addr_even = {8'h50, 7'(rand_bits(7)), 1'b0};
			addr_odd = {8'h51, 7'(rand_bits(7)), 1'b1};
			a = rand_byte();
			b = rand_byte();
			start_program("mem_operands", int'(rand_bits(1)));
			data_byte(addr_even, a);
			data_byte(addr_odd, b);
			ld_xl_dir(addr_even);
			st_xl(16'h6020);
			expect_write(16'h6020, a);
			op = random_op();
			alu_instr(op, SRC_MEM, addr_odd);
			st_xl(16'h6021);
			res = alu_ref(op, a, b, 5'b0);
			expect_write(16'h6021, res[7:0]);
			ld_xl_dir(addr_odd);
			st_xl(16'h6022);
			expect_write(16'h6022, b);
			op = random_op();
			alu_instr(op, SRC_MEM, addr_even);
			st_xl(16'h6023);
			res = alu_ref(op, b, a, res[12:8]);
			expect_write(16'h6023, res[7:0]);
			halt();
			run_program();
		end

		for (n = 0; n < 42; n++)
		begin
			a = rand_byte();
			b = rand_byte();
			op = random_op();
			start_program("branch", int'(rand_bits(1)));
			ld_xl_imm(a);
			alu_instr(op, SRC_IMM, {8'h00, b});
			st_xl(16'h6030);
			res = alu_ref(op, a, b, 5'b0);
			expect_write(16'h6030, res[7:0]);
			jr_rel(cond_t'(3'(n % 7)), 8'd3); // Taken lands past the trap
			halt();
			ld_xl_imm(8'h01);
			st_xl(16'h6031);
			halt();
			if (cond_holds(cond_t'(3'(n % 7)), res[12:8]))
				expect_write(16'h6031, 8'h01);
			run_program();
		end

		for (n = 0; n < 6; n++)
		begin
			a = rand_byte();
			dst = 16'h4100 + 16'(rand_bits(8));
			start_program("jump", int'(rand_bits(1)));
			ld_xl_imm(a);
			jp_abs(dst);
			halt();
			loc = dst;
			st_xl(16'h6040);
			halt();
			expect_write(16'h6040, a);
			run_program();
		end

		for (n = 0; n < 4; n++)
		begin
			a = rand_byte();
			b = rand_byte();
			start_program("alignment", n);
			ld_xl_imm(a);
			st_xl(16'h6050 + 16'(4 * n));
			pad_nop();
			st_xl(16'h6053 + 16'(4 * n));
			ld_xl_imm(b);
			pad_nop();
			st_xl(16'h6052 + 16'(4 * n));
			halt();
			expect_write(16'h6050 + 16'(4 * n), a);
			expect_write(16'h6053 + 16'(4 * n), a);
			expect_write(16'h6052 + 16'(4 * n), b);
			run_program();
		end

		$display("Checked %0d writes, %0d write errors, %0d run errors", checks, write_errors,
			run_errors);
		if (write_errors == 0 && run_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end
endmodule

`default_nettype wire

// File: source/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_top
(
	input logic clk,
	input logic reset,
	output logic [`CPU_BANK_ADDR_W-1:0] rd_addr_even,
	input logic [`CPU_DATA_W-1:0] rd_data_even,
	output logic [`CPU_BANK_ADDR_W-1:0] wr_addr_even,
	output logic [`CPU_DATA_W-1:0] wr_data_even,
	output logic wr_en_even,
	output logic [`CPU_BANK_ADDR_W-1:0] rd_addr_odd,
	input logic [`CPU_DATA_W-1:0] rd_data_odd,
	output logic [`CPU_BANK_ADDR_W-1:0] wr_addr_odd,
	output logic [`CPU_DATA_W-1:0] wr_data_odd,
	output logic wr_en_odd,
	output logic trap
);
	logic [`CPU_WORD_W-1:0] x;
	logic [`CPU_WORD_W-1:0] y;
	logic [`CPU_WORD_W-1:0] z;
	logic [`CPU_FLAG_W-1:0] flags;
	logic [`CPU_FLAG_W-1:0] next_flags;
	logic [`CPU_ADDR_W-1:0] pc;
	logic [`CPU_ADDR_W-1:0] next_pc;
	logic [1:0] reg_wr_en;
	logic [1:0] reg_wr_sel;
	logic [`CPU_WORD_W-1:0] reg_wr_data;
	logic [`CPU_ADDR_W-1:0] mem_wr_addr;
	logic [`CPU_WORD_W-1:0] mem_wr_data;
	logic [1:0] mem_wr_en;

	decoded_if dec_bus ();

	cpu_decode decode (.clk, .reset, .pc, .next_pc, .rd_addr_even, .rd_addr_odd,
		.rd_data_even, .rd_data_odd, .dec(dec_bus.decode));

	cpu_execute execute (.x, .y, .z, .flags, .pc, .dec(dec_bus.exec), .reg_wr_en,
		.reg_wr_sel, .reg_wr_data, .next_flags, .next_pc, .mem_wr_addr, .mem_wr_data,
		.mem_wr_en, .trap);

	cpu_result result (.clk, .reset, .reg_wr_en, .reg_wr_sel, .reg_wr_data, .next_flags,
		.next_pc, .mem_wr_addr, .mem_wr_data, .mem_wr_en, .x, .y, .z, .flags, .pc,
		.wr_addr_even, .wr_addr_odd, .wr_data_even, .wr_data_odd, .wr_en_even, .wr_en_odd);
endmodule

`default_nettype wire

// File: source/cpu_result.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_result
(
	input logic clk,
	input logic reset,
	input logic [1:0] reg_wr_en,
	input logic [1:0] reg_wr_sel,
	input logic [`CPU_WORD_W-1:0] reg_wr_data,
	input logic [`CPU_FLAG_W-1:0] next_flags,
	input logic [`CPU_ADDR_W-1:0] next_pc,
	input logic [`CPU_ADDR_W-1:0] mem_wr_addr,
	input logic [`CPU_WORD_W-1:0] mem_wr_data,
	input logic [1:0] mem_wr_en,
	output logic [`CPU_WORD_W-1:0] x,
	output logic [`CPU_WORD_W-1:0] y,
	output logic [`CPU_WORD_W-1:0] z,
	output logic [`CPU_FLAG_W-1:0] flags,
	output logic [`CPU_ADDR_W-1:0] pc,
	output logic [`CPU_BANK_ADDR_W-1:0] wr_addr_even,
	output logic [`CPU_BANK_ADDR_W-1:0] wr_addr_odd,
	output logic [`CPU_DATA_W-1:0] wr_data_even,
	output logic [`CPU_DATA_W-1:0] wr_data_odd,
	output logic wr_en_even,
	output logic wr_en_odd
);
	logic [`CPU_WORD_W-1:0] regs [3]; // x, y, z

	assign x = regs[0];
	assign y = regs[1];
	assign z = regs[2];

	// Independent byte lanes
	always_ff @(posedge clk)
	begin
		if (reg_wr_en[0])
			regs[reg_wr_sel][7:0] <= reg_wr_data[7:0];
		if (reg_wr_en[1])
			regs[reg_wr_sel][15:8] <= reg_wr_data[15:8];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			flags <= '0;
			pc <= `CPU_RESET_PC;
		end
		else
		begin
			flags <= next_flags;
			pc <= next_pc;
		end
	end

	// Odd address puts the low byte in the odd bank and the high byte in the next even word
	assign wr_addr_odd = mem_wr_addr[15:1];
	assign wr_addr_even = mem_wr_addr[15:1] + {{(`CPU_BANK_ADDR_W-1){1'b0}}, mem_wr_addr[0]};
	assign wr_data_even = mem_wr_addr[0] ? mem_wr_data[15:8] : mem_wr_data[7:0];
	assign wr_data_odd = mem_wr_addr[0] ? mem_wr_data[7:0] : mem_wr_data[15:8];
	assign wr_en_even = mem_wr_addr[0] ? mem_wr_en[1] : mem_wr_en[0];
	assign wr_en_odd = mem_wr_addr[0] ? mem_wr_en[0] : mem_wr_en[1];
endmodule

`default_nettype wire

// File: source/cpu_execute.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_execute
(
	input logic [`CPU_WORD_W-1:0] x,
	input logic [`CPU_WORD_W-1:0] y,
	input logic [`CPU_WORD_W-1:0] z,
	input logic [`CPU_FLAG_W-1:0] flags,
	input logic [`CPU_ADDR_W-1:0] pc,
	decoded_if.exec dec,
	output logic [1:0] reg_wr_en,
	output logic [1:0] reg_wr_sel,
	output logic [`CPU_WORD_W-1:0] reg_wr_data,
	output logic [`CPU_FLAG_W-1:0] next_flags,
	output logic [`CPU_ADDR_W-1:0] next_pc,
	output logic [`CPU_ADDR_W-1:0] mem_wr_addr,
	output logic [`CPU_WORD_W-1:0] mem_wr_data,
	output logic [1:0] mem_wr_en,
	output logic trap
);
	import cpu_pkg::*;

	logic [`CPU_DATA_W-1:0] acc;
	logic [`CPU_DATA_W-1:0] operand;
	logic [`CPU_DATA_W-1:0] addend;
	logic [`CPU_DATA_W-1:0] result;
	logic [`CPU_DATA_W:0] sum;
	logic [4:0] half_sum;
	logic carry_in;
	logic arith;
	logic taken;
	logic [1:0] size;
	logic [`CPU_ADDR_W-1:0] disp;

	assign acc = x[7:0];

	always_comb
	begin
		case (dec.src)
			SRC_XH: operand = x[15:8];
			SRC_YL: operand = y[7:0];
			SRC_YH: operand = y[15:8];
			SRC_ZL: operand = z[7:0];
			SRC_MEM: operand = dec.mem_byte;
			default: operand = dec.imm16[7:0];
		endcase
	end

	// Subtract by adding the complement, C then means no borrow
	assign arith = dec.alu_op inside {ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC};
	assign addend = (dec.alu_op inside {ALU_SUB, ALU_SBC}) ? ~operand : operand;

	always_comb
	begin
		case (dec.alu_op)
			ALU_ADC, ALU_SBC: carry_in = flags[FLAG_C];
			ALU_SUB: carry_in = 1'b1;
			default: carry_in = 1'b0;
		endcase
	end

	assign sum = {1'b0, acc} + {1'b0, addend} + {8'h00, carry_in};
	assign half_sum = {1'b0, acc[3:0]} + {1'b0, addend[3:0]} + {4'h0, carry_in};

	always_comb
	begin
		case (dec.alu_op)
			ALU_AND: result = acc & operand;
			ALU_OR: result = acc | operand;
			ALU_XOR: result = acc ^ operand;
			ALU_PASS: result = operand; // Loads into xl
			default: result = sum[7:0];
		endcase
	end

	always_comb
	begin
		next_flags = flags;
		if (dec.execute && dec.wr_xl && dec.alu_op != ALU_PASS)
		begin
			next_flags[FLAG_N] = result[7];
			next_flags[FLAG_Z] = result == 8'h00;
			if (arith)
			begin
				next_flags[FLAG_H] = half_sum[4];
				next_flags[FLAG_C] = sum[8];
				next_flags[FLAG_O] = (acc[7] == addend[7]) && (sum[7] != acc[7]);
			end
		end
	end

	always_comb
	begin
		reg_wr_en = 2'b00;
		reg_wr_sel = 2'd0; // x
		reg_wr_data = {8'h00, result};
		mem_wr_en = 2'b00;
		mem_wr_addr = dec.imm16;
		mem_wr_data = {8'h00, acc};
		if (dec.execute)
		begin
			if (dec.wr_xl)
				reg_wr_en = 2'b01;
			else if (dec.wr_word)
			begin
				reg_wr_en = 2'b11;
				reg_wr_sel = dec.word_reg;
				reg_wr_data = dec.imm16;
			end
			if (dec.st_dir)
				mem_wr_en = 2'b01;
		end
	end

	always_comb
	begin
		case (dec.cond)
			COND_Z: taken = flags[FLAG_Z];
			COND_NZ: taken = !flags[FLAG_Z];
			COND_C: taken = flags[FLAG_C];
			COND_NC: taken = !flags[FLAG_C];
			COND_N: taken = flags[FLAG_N];
			COND_NN: taken = !flags[FLAG_N];
			default: taken = 1'b1;
		endcase
	end

	// Instruction length from its class
	always_comb
	begin
		if (dec.wr_word || dec.st_dir || dec.jump || dec.wr_xl && dec.src == SRC_MEM)
			size = 2'd3;
		else if (dec.jr || dec.wr_xl && dec.src == SRC_IMM)
			size = 2'd2;
		else
			size = 2'd1;
	end

	assign disp = {{8{dec.imm16[7]}}, dec.imm16[7:0]};
	assign trap = dec.execute && dec.trap;

	always_comb
	begin
		if (!dec.execute || dec.trap)
			next_pc = pc; // Holds trap in place
		else if (dec.jump)
			next_pc = dec.imm16;
		else if (dec.jr && taken)
			next_pc = pc + disp;
		else
			next_pc = pc + {14'd0, size};
	end
endmodule

`default_nettype wire

// File: source/cpu_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

module cpu_decode
(
	input logic clk,
	input logic reset,
	input logic [`CPU_ADDR_W-1:0] pc,
	input logic [`CPU_ADDR_W-1:0] next_pc,
	output logic [`CPU_BANK_ADDR_W-1:0] rd_addr_even,
	output logic [`CPU_BANK_ADDR_W-1:0] rd_addr_odd,
	input logic [`CPU_DATA_W-1:0] rd_data_even,
	input logic [`CPU_DATA_W-1:0] rd_data_odd,
	decoded_if.decode dec
);
	import cpu_pkg::*;

	logic [3*`CPU_DATA_W-1:0] held; // Instruction register
	logic upper_pending; // Third byte arrives this cycle
	logic operand_pending; // Operand byte arrives this cycle
	logic restart;
	logic [2*`CPU_DATA_W-1:0] fetched;
	logic [3*`CPU_DATA_W-1:0] inst;
	opcode_t opcode;
	logic alu_form;
	logic needs_upper;
	logic needs_operand;
	logic [`CPU_ADDR_W-1:0] fetch_addr;

	// Both bits set only after reset, replays the held NOP while the first fetch is in flight
	assign restart = upper_pending && operand_pending;

	// Bytes back in address order
	assign fetched = pc[0] ? {rd_data_even, rd_data_odd} : {rd_data_odd, rd_data_even};

	always_comb
	begin
		if (operand_pending)
			inst = held;
		else if (upper_pending)
			inst = {pc[0] ? rd_data_odd : rd_data_even, held[15:0]}; // Upper byte of pc+1 read
		else
			inst = {8'h00, fetched};
	end

	assign opcode = opcode_t'(inst[7:0]);
	assign alu_form = inst[7:4] >= 4'h1 && inst[7:4] <= 4'h6 && inst[3:0] <= 4'h6;

	always_comb
	begin
		dec.alu_op = ALU_PASS;
		dec.src = SRC_IMM;
		dec.wr_xl = 1'b0;
		dec.wr_word = 1'b0;
		dec.word_reg = inst[1:0];
		dec.st_dir = 1'b0;
		dec.jump = 1'b0;
		dec.jr = 1'b0;
		dec.cond = COND_ALWAYS;
		dec.trap = 1'b0;
		needs_upper = 1'b0;
		needs_operand = 1'b0;
		if (alu_form)
		begin
			dec.alu_op = alu_op_t'(inst[2:0]);
			dec.src = src_t'(inst[6:4] - 3'd1);
			dec.wr_xl = 1'b1;
			needs_upper = inst[7:4] == 4'h6;
			needs_operand = inst[7:4] == 4'h6;
		end
		else
		begin
			case (opcode)
				OP_LD_XL_IMM:
					dec.wr_xl = 1'b1;
				OP_LD_XL_DIR:
				begin
					dec.wr_xl = 1'b1;
					dec.src = SRC_MEM;
					needs_upper = 1'b1;
					needs_operand = 1'b1;
				end
				OP_LD_DIR_XL:
				begin
					dec.st_dir = 1'b1;
					needs_upper = 1'b1;
				end
				OP_LDW_X_IMM, OP_LDW_Y_IMM, OP_LDW_Z_IMM:
				begin
					dec.wr_word = 1'b1;
					needs_upper = 1'b1;
				end
				OP_JP_IMM:
				begin
					dec.jump = 1'b1;
					needs_upper = 1'b1;
				end
				OP_JR, OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC, OP_JRN, OP_JRNN:
				begin
					dec.jr = 1'b1;
					dec.cond = cond_t'(inst[2:0]);
				end
				OP_TRAP:
					dec.trap = 1'b1;
				default:
					dec.trap = 1'b0; // Anything else runs as nop
			endcase
		end
	end

	assign dec.imm16 = inst[23:8];
	assign dec.mem_byte = inst[8] ? rd_data_odd : rd_data_even; // By direct address parity
	assign dec.execute = !restart && (upper_pending || operand_pending || !needs_upper)
		&& (operand_pending || !needs_operand);

	always_comb
	begin
		if (!upper_pending && !operand_pending && needs_upper)
			fetch_addr = pc + 16'd1;
		else if (upper_pending && !operand_pending && needs_operand)
			fetch_addr = inst[23:8];
		else
			fetch_addr = next_pc;
	end

	assign rd_addr_odd = fetch_addr[15:1];
	assign rd_addr_even = fetch_addr[15:1] + {{(`CPU_BANK_ADDR_W-1){1'b0}}, fetch_addr[0]};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			held <= {16'h0000, OP_NOP};
			upper_pending <= 1'b1;
			operand_pending <= 1'b1;
		end
		else
		begin
			held <= inst;
			upper_pending <= !upper_pending && !operand_pending && needs_upper;
			operand_pending <= upper_pending && !operand_pending && needs_operand;
		end
	end
endmodule

`default_nettype wire

// File: source/decoded_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_params.svh"

interface decoded_if;
	import cpu_pkg::*;

	logic execute; // Instruction complete this cycle
	alu_op_t alu_op;
	src_t src;
	logic [`CPU_ADDR_W-1:0] imm16; // Immediate, direct address or displacement
	logic [`CPU_DATA_W-1:0] mem_byte;
	logic wr_xl;
	logic wr_word;
	logic [1:0] word_reg;
	logic st_dir;
	logic jump;
	logic jr;
	cond_t cond;
	logic trap;

	modport decode (output execute, alu_op, src, imm16, mem_byte, wr_xl, wr_word, word_reg,
		st_dir, jump, jr, cond, trap);
	modport exec (input execute, alu_op, src, imm16, mem_byte, wr_xl, wr_word, word_reg,
		st_dir, jump, jr, cond, trap);
endinterface

`default_nettype wire

// File: source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	// High nibble 1 to 6 is the operand form, low three bits the ALU operation
	typedef enum logic [7:0]
	{
		OP_NOP = 8'h00,
		OP_TRAP = 8'h01,
		OP_ADD_IMM = 8'h10, OP_ADC_IMM = 8'h11, OP_SUB_IMM = 8'h12, OP_SBC_IMM = 8'h13,
		OP_AND_IMM = 8'h14, OP_OR_IMM = 8'h15, OP_XOR_IMM = 8'h16,
		OP_ADD_XH = 8'h20, OP_ADC_XH = 8'h21, OP_SUB_XH = 8'h22, OP_SBC_XH = 8'h23,
		OP_AND_XH = 8'h24, OP_OR_XH = 8'h25, OP_XOR_XH = 8'h26,
		OP_ADD_YL = 8'h30, OP_ADC_YL = 8'h31, OP_SUB_YL = 8'h32, OP_SBC_YL = 8'h33,
		OP_AND_YL = 8'h34, OP_OR_YL = 8'h35, OP_XOR_YL = 8'h36,
		OP_ADD_YH = 8'h40, OP_ADC_YH = 8'h41, OP_SUB_YH = 8'h42, OP_SBC_YH = 8'h43,
		OP_AND_YH = 8'h44, OP_OR_YH = 8'h45, OP_XOR_YH = 8'h46,
		OP_ADD_ZL = 8'h50, OP_ADC_ZL = 8'h51, OP_SUB_ZL = 8'h52, OP_SBC_ZL = 8'h53,
		OP_AND_ZL = 8'h54, OP_OR_ZL = 8'h55, OP_XOR_ZL = 8'h56,
		OP_ADD_DIR = 8'h60, OP_ADC_DIR = 8'h61, OP_SUB_DIR = 8'h62, OP_SBC_DIR = 8'h63,
		OP_AND_DIR = 8'h64, OP_OR_DIR = 8'h65, OP_XOR_DIR = 8'h66,
		OP_LD_XL_IMM = 8'h70,
		OP_LD_XL_DIR = 8'h71,
		OP_LD_DIR_XL = 8'h72,
		OP_LDW_X_IMM = 8'h74, // Low two bits pick the register
		OP_LDW_Y_IMM = 8'h75,
		OP_LDW_Z_IMM = 8'h76,
		OP_JP_IMM = 8'h78,
		OP_JR = 8'h80, // Low three bits are the cond_t code
		OP_JRZ = 8'h81, OP_JRNZ = 8'h82, OP_JRC = 8'h83, OP_JRNC = 8'h84,
		OP_JRN = 8'h85, OP_JRNN = 8'h86
	} opcode_t;

	typedef enum logic [2:0]
	{
		FLAG_H, // Half carry
		FLAG_C,
		FLAG_N,
		FLAG_Z,
		FLAG_O // Signed overflow
	} flag_t;

	typedef enum logic [2:0]
	{
		ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS
	} alu_op_t;

	typedef enum logic [2:0]
	{
		SRC_IMM, SRC_XH, SRC_YL, SRC_YH, SRC_ZL, SRC_MEM
	} src_t;

	typedef enum logic [2:0]
	{
		COND_ALWAYS, COND_Z, COND_NZ, COND_C, COND_NC, COND_N, COND_NN
	} cond_t;

endpackage

`default_nettype wire

// File: source/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Datapath widths
`define CPU_DATA_W 8
`define CPU_WORD_W 16
`define CPU_ADDR_W 16
`define CPU_FLAG_W 5

// Two byte-wide banks, even and odd byte addresses
`define CPU_BANK_ADDR_W 15
`define CPU_BANK_DEPTH (1 << `CPU_BANK_ADDR_W)

`define CPU_RESET_PC 16'h4000 // First fetched address

`endif
